//--- project.f
cache_pkg.sv
cache_store.sv
cache_lookup.sv
flush_counter.sv
cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the L1 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_cache -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_l1_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if echo "$out" | grep -q "^Everything OK$"; then
    exit 0
fi
exit 1

//--- tb_l1_cache.sv
// testbench for the L1 data cache
// drives the processor port, checks read data against a scoreboard of memory
// and checks memory traffic through the counters of the memory model
`timescale 1ns/100ps

module tb_l1_cache import cache_pkg::*; ();

    localparam int TIMEOUT = 1000;

    logic      CLK;
    logic      nRST;
    logic      flush;
    proc_req_t req;
    proc_rsp_t rsp;
    mem_req_t  mreq;
    mem_rsp_t  mrsp;
    logic      flush_done;
    word_t     sb [word_t];   // scoreboard of written words
    word_t     lfsr = 32'h5454;
    int        errors = 0;
    int        checks = 0;
    int        test_start = 0;

    l1_cache l1_cache_inst (
        .CLK(CLK), .nRST(nRST), .flush(flush), .proc_req(req), .proc_rsp(rsp),
        .mem_req(mreq), .mem_rsp(mrsp), .flush_done(flush_done)
    );

    tb_mem_model mem (.CLK(CLK), .nRST(nRST), .mem_req(mreq), .mem_rsp(mrsp));

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic word_t expected(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (sb.exists(wa)) return sb[wa];
        return {2'b00, a[31:2]} ^ 32'hA5A5_0000;
    endfunction

    function automatic void sb_write(input word_t a, input word_t d, input byte_en_t be);
        word_t w;
        w = expected(a);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[8*b +: 8] = d[8*b +: 8];
        end
        sb[{a[31:2], 2'b00}] = w;
    endfunction

    // one LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("check failed: %s", what);
            errors++;
        end
    endtask

    task automatic access(input logic is_wr, input word_t addr, input word_t data,
                          input byte_en_t be, output word_t rdata);
        bit done;
        done  = 0;
        rdata = '0;
        @(posedge CLK);
        req.ren     <= !is_wr;
        req.wen     <= is_wr;
        req.addr    <= addr;
        req.wdata   <= data;
        req.byte_en <= be;
        for (int n = 0; n < TIMEOUT && !done; n++) begin
            @(negedge CLK);
            if (!rsp.busy) begin
                done  = 1;
                rdata = rsp.rdata;
            end
        end
        if (!done) begin
            $display("timeout, access to %h never completed", addr);
            errors++;
        end
        @(posedge CLK);
        req <= '0;
        @(negedge CLK);   // memory log settled
    endtask

    task automatic read_check(input word_t addr);
        word_t got;
        access(1'b0, addr, '0, 4'hF, got);
        check_word("proc_rsp.rdata", got, expected(addr));
    endtask

    task automatic write_word(input word_t addr, input word_t data, input byte_en_t be);
        word_t unused;
        access(1'b1, addr, data, be, unused);
        sb_write(addr, data, be);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s (%0d errors)", name,
                 (errors == test_start) ? "passed" : "failed", errors - test_start);
        test_start = errors;
    endtask

    task automatic do_flush();
        int pulses;
        pulses = 0;
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        for (int n = 0; n < TIMEOUT && pulses == 0; n++) begin
            @(negedge CLK);
            if (flush_done) pulses++;
        end
        if (pulses == 0) begin
            $display("timeout, flush_done never came");
            errors++;
        end
        repeat (8) begin
            @(negedge CLK);
            if (flush_done) pulses++;
        end
        check_true(pulses == 1, "flush_done did not pulse exactly once");
    endtask

    function automatic logic logged_since(input int start, input word_t a);
        for (int i = start; i < mem.wr_log.size(); i++) begin
            if (mem.wr_log[i] == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    initial begin
        int    rc;
        int    wc;
        int    ws;
        word_t r;
        word_t a;
        word_t d;
        word_t be;
        word_t blocks [3];
        nRST  = 1'b0;
        flush = 1'b0;
        req   = '0;
        repeat (3) @(posedge CLK);
        nRST        <= 1'b1;
        req.ren     <= 1'b1;   // read held through the clear walk
        req.addr    <= 32'h100;
        req.byte_en <= 4'hF;

        // clear walk, no traffic and busy held
        for (int i = 0; i < N_SETS * ASSOC; i++) begin
            @(negedge CLK);
            check_true(rsp.busy && !mreq.ren && !mreq.wen, "activity during the clear walk");
        end
        rc = mem.rd_count;
        read_check(32'h100);
        check_true(mem.rd_count == rc + 1, "first read did not fetch from memory");
        read_check(32'h100);
        check_true(mem.rd_count == rc + 1, "repeated read went to memory");
        end_test("reset and first read");

        wc = mem.wr_count;
        write_word(32'h100, 32'h1122_3344, 4'b0001);
        write_word(32'h104, 32'hAABB_CCDD, 4'b1100);
        write_word(32'h101, 32'h0000_7700, 4'b0010);
        read_check(32'h100);
        read_check(32'h104);
        write_word(32'h104, 32'hDEAD_BEEF, 4'b1111);
        read_check(32'h104);
        check_true(mem.wr_count == wc, "write hit reached memory");
        end_test("byte-enabled write hits");

        read_check(32'h500);
        wc = mem.wr_count;
        rc = mem.rd_count;
        read_check(32'h900);   // evicts the dirty 0x100 block
        check_true(mem.wr_count == wc + 1, "dirty victim not written back");
        check_word("mem_req.addr", mem.last_wr_addr, 32'h100);
        check_true(mem.rd_count == rc + 1, "eviction miss did not fill");
        check_true(mem.last_wr_seq < mem.last_rd_seq, "fill came before the write-back");
        read_check(32'h100);
        read_check(32'h104);
        end_test("dirty eviction");

        blocks = '{32'h200, 32'h308, 32'h408};
        write_word(32'h200, 32'h0BAD_F00D, 4'b1111);
        write_word(32'h30C, 32'h5555_AAAA, 4'b0110);
        write_word(32'h40C, 32'hCAFE_0001, 4'b1000);
        ws = mem.wr_log.size();
        do_flush();
        foreach (blocks[i]) begin
            check_true(logged_since(ws, blocks[i]), "dirty block missing from flush writes");
            rc = mem.rd_count;
            read_check(blocks[i]);
            check_true(mem.rd_count == rc + 1, "address still cached after flush");
        end
        read_check(32'h30C);
        read_check(32'h40C);
        end_test("flush");

        rc = mem.rd_count;
        read_check(32'hF000_0010);
        check_true(mem.rd_count == rc + 1, "uncached read missed memory");
        check_word("mem_req.addr", mem.last_rd_addr, 32'hF000_0010);
        write_word(32'hF000_0020, 32'h1234_5678, 4'b0010);
        check_word("mem_req.addr", mem.last_wr_addr, 32'hF000_0020);
        check_word("mem_req.byte_en", 32'(mem.last_wr_be), 32'h2);
        check_word("mem_req.wdata[0]", mem.last_wr_lane0, 32'h0000_5600);
        read_check(32'hF000_0010);
        check_true(mem.rd_count == rc + 2, "repeated uncached read not sent to memory");
        read_check(32'hF000_0020);
        end_test("uncached pass-through");

        for (int i = 0; i < 60; i++) begin
            a = rand_bits(3);
            r = rand_bits(2);
            a = (a << 2) | (r << 10);   // four sets, four tags
            r = rand_bits(1);
            if (r[0]) begin
                be = rand_bits(4);
                d  = rand_bits(32);
                write_word(a, d, (be[3:0] == 4'h0) ? 4'hF : be[3:0]);
            end else begin
                read_check(a);
            end
        end
        end_test("random traffic");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tb_mem_model.sv
// block-wide memory model for the L1 cache testbench
// answers every request after a fixed three-cycle wait
// unwritten word at byte address x reads (x >> 2) ^ 32'hA5A5_0000
// keeps counters and a log of written block addresses for the checks
`timescale 1ns/100ps

module tb_mem_model import cache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int WAIT_CYCLES = 3;

    word_t    store [word_t];
    word_t    wr_log [$];
    int       wait_cnt = 0;
    int       rd_count = 0;
    int       wr_count = 0;
    int       op_seq = 0;
    int       last_rd_seq = 0;
    int       last_wr_seq = 0;
    word_t    last_rd_addr = '0;
    word_t    last_wr_addr = '0;
    word_t    last_wr_lane0 = '0;
    byte_en_t last_wr_be = '0;
    logic     active;

    function automatic word_t peek(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (store.exists(wa)) begin
            return store[wa];
        end
        return {2'b00, a[31:2]} ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t merge(input word_t old, input word_t nw, input byte_en_t be);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    assign active = mem_req.ren || mem_req.wen;

    always_comb begin
        mem_rsp.dwait = !(active && wait_cnt == WAIT_CYCLES);
        for (int k = 0; k < BLOCK_SIZE; k++) begin
            mem_rsp.rdata[k] = peek(mem_req.addr + 32'(4 * k));
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 0;
        end else if (!active) begin
            wait_cnt <= 0;
        end else if (wait_cnt != WAIT_CYCLES) begin
            wait_cnt <= wait_cnt + 1;
        end else begin
            wait_cnt <= 0;
            op_seq   = op_seq + 1;
            if (mem_req.ren) begin
                rd_count     = rd_count + 1;
                last_rd_addr = mem_req.addr;
                last_rd_seq  = op_seq;
            end
            if (mem_req.wen) begin
                wr_count      = wr_count + 1;
                last_wr_addr  = mem_req.addr;
                last_wr_be    = mem_req.byte_en;
                last_wr_lane0 = mem_req.wdata[0];
                last_wr_seq   = op_seq;
                wr_log.push_back(mem_req.addr);
                if (mem_req.addr >= NONCACHE_START) begin   // single word on lane 0
                    store[{mem_req.addr[31:2], 2'b00}] =
                        merge(peek(mem_req.addr), mem_req.wdata[0], mem_req.byte_en);
                end else begin
                    for (int k = 0; k < BLOCK_SIZE; k++) begin
                        store[mem_req.addr + 32'(4 * k)] = mem_req.wdata[k];
                    end
                end
            end
        end
    end

endmodule

//--- l1_cache.sv
// top level of the L1 data cache
// connects the array, the hit lookup, the frame walk counter and the FSM
// processor side holds requests until busy drops, memory side waits on dwait
`timescale 1ns/100ps

module l1_cache import cache_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      flush,
    input  proc_req_t proc_req,
    output proc_rsp_t proc_rsp,
    output mem_req_t  mem_req,
    input  mem_rsp_t  mem_rsp,
    output logic      flush_done
);

    cache_set_t            rset;
    cache_set_t            wset;
    cache_set_t            wmask;
    logic                  store_wen;
    logic [N_SET_BITS-1:0] store_sel;
    logic                  hit;
    logic [N_WAY_BITS-1:0] hit_way;
    logic [N_WAY_BITS-1:0] victim_way;
    word_t                 hit_word;
    logic [N_SETS-1:0]     last_used;
    walk_idx_t             walk;
    logic                  walk_clear;
    logic                  walk_step;

    cache_store u_store (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (store_wen),
        .sel   (store_sel),
        .wset  (wset),
        .wmask (wmask),
        .rset  (rset)
    );

    cache_lookup u_lookup (
        .rset       (rset),
        .addr       (cache_addr_t'(proc_req.addr)),
        .last_used  (last_used),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .hit_word   (hit_word)
    );

    flush_counter u_walk (
        .CLK   (CLK),
        .nRST  (nRST),
        .clear (walk_clear),
        .step  (walk_step),
        .idx   (walk)
    );

    cache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush_done (flush_done),
        .rset       (rset),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .hit_word   (hit_word),
        .walk       (walk),
        .store_wen  (store_wen),
        .store_sel  (store_sel),
        .wset       (wset),
        .wmask      (wmask),
        .walk_clear (walk_clear),
        .walk_step  (walk_step),
        .last_used  (last_used)
    );

endmodule

//--- cache_ctrl.sv
// control FSM of the write-back L1 data cache
// serves hits in HIT, fills misses in FETCH after a WB of a dirty victim,
// clears every frame after reset and walks all frames on a flush
// uncached requests are passed to the memory port on word lane 0
`timescale 1ns/100ps

module cache_ctrl import cache_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  flush,
    input  proc_req_t             proc_req,
    output proc_rsp_t             proc_rsp,
    output mem_req_t              mem_req,
    input  mem_rsp_t              mem_rsp,
    output logic                  flush_done,
    input  cache_set_t            rset,
    input  logic                  hit,
    input  logic [N_WAY_BITS-1:0] hit_way,
    input  logic [N_WAY_BITS-1:0] victim_way,
    input  word_t                 hit_word,
    input  walk_idx_t             walk,
    output logic                  store_wen,
    output logic [N_SET_BITS-1:0] store_sel,
    output cache_set_t            wset,
    output cache_set_t            wmask,
    output logic                  walk_clear,
    output logic                  walk_step,
    output logic [N_SETS-1:0]     last_used
);

    cache_state_t      state, next_state;
    logic              flush_req;
    logic [N_SETS-1:0] next_last_used;
    word_t             wb_addr;
    logic              wb_load;
    cache_addr_t       req_addr;
    cache_frame_t      victim;
    cache_frame_t      walk_frame;
    logic              pass_through;
    logic              access;
    word_t             be_bits;

    // ones in every enabled byte lane
    function automatic word_t lane_bits(input byte_en_t be);
        word_t bits;
        for (int b = 0; b < 4; b++) begin
            bits[8*b +: 8] = {8{be[b]}};
        end
        return bits;
    endfunction

    assign req_addr     = proc_req.addr;
    assign pass_through = proc_req.addr >= NONCACHE_START;
    assign access       = proc_req.ren || proc_req.wen;
    assign victim       = rset[victim_way];
    assign walk_frame   = rset[walk.way_num];
    assign be_bits      = lane_bits(proc_req.byte_en);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= CLEAR;
            flush_req <= 1'b0;
            last_used <= '0;
        end else begin
            state     <= next_state;
            last_used <= next_last_used;
            if (flush_done) begin
                flush_req <= 1'b0;
            end else if (flush) begin
                flush_req <= 1'b1;   // held until the walk ends
            end
        end
    end

    // victim block address, captured on the way into WB
    always_ff @(posedge CLK) begin
        if (wb_load) begin
            wb_addr <= {victim.tag, req_addr.set_idx, {N_BLOCK_BITS{1'b0}}, 2'b00};
        end
    end

    always_comb begin
        next_state     = state;
        next_last_used = last_used;
        wb_load        = 1'b0;
        store_wen      = 1'b0;
        store_sel      = req_addr.set_idx;
        wset           = '0;
        wmask          = '1;
        walk_clear     = 1'b0;
        walk_step      = 1'b0;
        flush_done     = 1'b0;
        proc_rsp.busy  = 1'b1;
        proc_rsp.rdata = '0;
        mem_req        = '0;

        case (state)
            CLEAR: begin
                store_sel = walk.set_num;
                if (walk.finish) begin
                    walk_clear = 1'b1;
                    next_state = HIT;
                end else begin
                    store_wen           = 1'b1;
                    wmask[walk.way_num] = '0;   // zero the whole frame
                    walk_step           = 1'b1;
                end
            end

            HIT: begin
                if (flush || flush_req) begin
                    next_state = FLUSH;
                end else if (access && pass_through) begin
                    mem_req.ren      = proc_req.ren;
                    mem_req.wen      = proc_req.wen;
                    mem_req.addr     = proc_req.addr;
                    mem_req.byte_en  = proc_req.byte_en;
                    mem_req.wdata[0] = proc_req.wdata & be_bits;   // unused bytes zero
                    proc_rsp.busy    = mem_rsp.dwait;
                    proc_rsp.rdata   = mem_rsp.rdata[0];
                end else if (proc_req.ren && hit) begin
                    proc_rsp.busy                    = 1'b0;
                    proc_rsp.rdata                   = hit_word;
                    next_last_used[req_addr.set_idx] = hit_way;
                end else if (proc_req.wen && hit) begin
                    proc_rsp.busy                    = 1'b0;
                    store_wen                        = 1'b1;
                    wset[hit_way].data[req_addr.word_idx]  = proc_req.wdata;
                    wmask[hit_way].data[req_addr.word_idx] = ~be_bits;
                    wset[hit_way].dirty              = 1'b1;
                    wmask[hit_way].dirty             = 1'b0;
                    next_last_used[req_addr.set_idx] = hit_way;
                end else if (access) begin
                    // miss, write back first if the victim holds new data
                    if (victim.valid && victim.dirty) begin
                        wb_load    = 1'b1;
                        next_state = WB;
                    end else begin
                        next_state = FETCH;
                    end
                end
            end

            FETCH: begin
                mem_req.ren     = 1'b1;
                mem_req.addr    = {req_addr.tag, req_addr.set_idx, {N_BLOCK_BITS{1'b0}}, 2'b00};
                mem_req.byte_en = '1;
                if (!mem_rsp.dwait) begin
                    store_wen              = 1'b1;
                    wset[victim_way].valid = 1'b1;
                    wset[victim_way].tag   = req_addr.tag;
                    wset[victim_way].data  = mem_rsp.rdata;   // filled clean
                    wmask[victim_way]      = '0;
                    next_state             = HIT;
                end
            end

            WB: begin
                mem_req.wen     = 1'b1;
                mem_req.addr    = wb_addr;
                mem_req.byte_en = '1;
                mem_req.wdata   = victim.data;
                if (!mem_rsp.dwait) begin
                    store_wen               = 1'b1;
                    wmask[victim_way].valid = 1'b0;   // invalidate once written out
                    wmask[victim_way].dirty = 1'b0;
                    next_state              = FETCH;
                end
            end

            FLUSH: begin
                store_sel = walk.set_num;
                if (walk.finish) begin
                    walk_clear = 1'b1;
                    flush_done = 1'b1;
                    next_state = HIT;
                end else if (walk_frame.valid && walk_frame.dirty) begin
                    mem_req.wen     = 1'b1;
                    mem_req.addr    = {walk_frame.tag, walk.set_num,
                                       {N_BLOCK_BITS{1'b0}}, 2'b00};
                    mem_req.byte_en = '1;
                    mem_req.wdata   = walk_frame.data;
                    if (!mem_rsp.dwait) begin
                        store_wen           = 1'b1;
                        wmask[walk.way_num] = '0;
                        walk_step           = 1'b1;
                    end
                end else begin
                    // clean or empty, just drop it
                    store_wen           = 1'b1;
                    wmask[walk.way_num] = '0;
                    walk_step           = 1'b1;
                end
            end

            default: next_state = HIT;
        endcase
    end

endmodule

//--- flush_counter.sv
// frame walk counter shared by the post-reset clear and the flush
// steps through the ways of a set, then on to the next set
// finish goes high after the last frame and holds until clear
`timescale 1ns/100ps

module flush_counter import cache_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      clear,
    input  logic      step,
    output walk_idx_t idx
);

    walk_idx_t next_idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            idx <= '0;
        end else begin
            idx <= next_idx;
        end
    end

    always_comb begin
        next_idx = idx;
        if (clear) begin
            next_idx = '0;
        end else if (step) begin
            if (idx.way_num == N_WAY_BITS'(ASSOC - 1)) begin
                next_idx.way_num = '0;
                if (idx.set_num == N_SET_BITS'(N_SETS - 1)) begin
                    next_idx.set_num = '0;   // wrap and flag the end
                    next_idx.finish  = 1'b1;
                end else begin
                    next_idx.set_num = idx.set_num + 1'b1;
                end
            end else begin
                next_idx.way_num = idx.way_num + 1'b1;
            end
        end
    end

endmodule

//--- cache_lookup.sv
// hit detection and victim choice for the set read from the store
// purely combinational; the uncached range is handled by the controller
`timescale 1ns/100ps

module cache_lookup import cache_pkg::*; (
    input  cache_set_t            rset,
    input  cache_addr_t           addr,
    input  logic [N_SETS-1:0]     last_used,
    output logic                  hit,
    output logic [N_WAY_BITS-1:0] hit_way,
    output logic [N_WAY_BITS-1:0] victim_way,
    output word_t                 hit_word
);

    logic [N_WAY_BITS-1:0] mru;

    // tag compare over all ways
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_word = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (rset[i].valid && rset[i].tag == addr.tag) begin
                hit      = 1'b1;
                hit_way  = N_WAY_BITS'(i);
                hit_word = rset[i].data[addr.word_idx];   // addressed word only
            end
        end
    end

    // NRU, evict the way after the last one touched
    assign mru        = N_WAY_BITS'(last_used[addr.set_idx]);
    assign victim_way = (mru == N_WAY_BITS'(ASSOC - 1)) ? '0 : mru + 1'b1;

endmodule

//--- cache_store.sv
// data and tag array of the L1 cache, one entry per set
// read is combinational on sel, write merges wset where wmask is zero
// contents are undefined out of reset, the controller clears them
`timescale 1ns/100ps

module cache_store import cache_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  wen,
    input  logic [N_SET_BITS-1:0] sel,
    input  cache_set_t            wset,
    input  cache_set_t            wmask,
    output cache_set_t            rset
);

    cache_set_t sets [N_SETS];
    cache_set_t merged;

    // a mask bit of one keeps the stored bit
    assign merged = (sets[sel] & wmask) | (wset & ~wmask);

    always_ff @(posedge CLK) begin
        if (nRST && wen) begin   // no writes while reset is held
            sets[sel] <= merged;
        end
    end

    assign rset = sets[sel];

endmodule

//--- cache_pkg.sv
// shared definitions for the L1 data cache
// geometry constants, address and frame overlays, the processor and memory
// bus bundles and the controller states
// every cache module pulls this in with a wildcard import
package cache_pkg;

    // geometry
    localparam int CACHE_SIZE   = 1024;   // data bytes
    localparam int BLOCK_SIZE   = 2;      // words per block
    localparam int ASSOC        = 2;
    localparam int N_SETS       = CACHE_SIZE / (4 * BLOCK_SIZE * ASSOC);
    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int N_WAY_BITS   = $clog2(ASSOC);
    localparam int N_TAG_BITS   = 32 - N_SET_BITS - N_BLOCK_BITS - 2;

    // everything from here up bypasses the arrays
    localparam logic [31:0] NONCACHE_START = 32'hF000_0000;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    typedef struct packed {
        logic [N_TAG_BITS-1:0]   tag;
        logic [N_SET_BITS-1:0]   set_idx;
        logic [N_BLOCK_BITS-1:0] word_idx;
        logic [1:0]              byte_idx;
    } cache_addr_t;   // same width as a 32-bit address

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [N_TAG_BITS-1:0] tag;
        word_t [BLOCK_SIZE-1:0] data;
    } cache_frame_t;

    typedef cache_frame_t [ASSOC-1:0] cache_set_t;

    // position of the clear / flush walk
    typedef struct packed {
        logic                  finish;
        logic [N_SET_BITS-1:0] set_num;
        logic [N_WAY_BITS-1:0] way_num;
    } walk_idx_t;

    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_rsp_t;

    typedef struct packed {
        logic                   ren;
        logic                   wen;
        word_t                  addr;
        byte_en_t               byte_en;
        word_t [BLOCK_SIZE-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   dwait;   // memory wait, high while busy
        word_t [BLOCK_SIZE-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        CLEAR,
        HIT,
        FETCH,
        WB,
        FLUSH
    } cache_state_t;

endpackage
